//--- Makefile
# Verilator build and run for the GPMC bridge testbench

VERILATOR ?= verilator
TOP       ?= gpmc_async_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# An aborted run counts as a failure in the log
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
verilog/gpmc_pkg.sv
verilog/fifo_buffer.sv
verilog/frame_counter.sv
verilog/gpmc_write_ctrl.sv
verilog/gpmc_read_port.sv
verilog/packet_watcher.sv
verilog/gpmc_async.sv
dv/gpmc_async_assert.sv
dv/gpmc_async_tb.sv

//--- dv/gpmc_async_assert.sv
// Concurrent protocol checks on the GPMC bridge top level
`default_nettype none

module gpmc_async_assert import gpmc_pkg::*; (
   input wire               fifo_clk,
   input wire               arst_n_i,
   input wire               em_ncs4_i,
   input wire               em_noe_i,
   input wire               em_d_oe_i,
   input wire               clear_tx_i,
   input wire [FRAME_W-1:0] tx_data_i,
   input wire               tx_src_rdy_i,
   input wire               tx_dst_rdy_i,
   input wire               rx_have_data_i,
   input wire               bus_error_i
);

   // TX stream is quiet while reset is held
   tx_quiet_in_reset: assert property (@(posedge fifo_clk) !arst_n_i |-> !tx_src_rdy_i)
      else $error("tx_src_rdy_o high during reset");

   // Pin drive is a plain decode of the raw strobes
   oe_decode: assert property (@(posedge fifo_clk)
      em_d_oe_i == (!em_ncs4_i && !em_noe_i))
      else $error("em_d_oe_o does not follow chip select and output enable");

   status_after_reset: assert property (@(posedge fifo_clk)
      $rose(arst_n_i) |-> !rx_have_data_i && !bus_error_i)
      else $error("rx_have_data_o or bus_error_o high after reset");

   // Stalled head word must hold
   tx_data_held: assert property (@(posedge fifo_clk) disable iff (!arst_n_i)
      tx_src_rdy_i && !tx_dst_rdy_i && !clear_tx_i |=> $stable(tx_data_i))
      else $error("tx_data_o changed while stalled");

endmodule

`default_nettype wire

//--- dv/gpmc_async_tb.sv
// Testbench for the GPMC bridge: host bus, stream drivers, reference model and checks
`default_nettype none

module gpmc_async_tb import gpmc_pkg::*; ();

   localparam int TX_AW    = 4;
   localparam int RX_AW    = 5;
   localparam int LEN_AW   = 3;
   localparam int TX_DEPTH = 1 << TX_AW;
   localparam int RX_DEPTH = 1 << RX_AW;
   localparam logic [31:0] SEED = 32'h7d3;

   // Word counts per test, which set the watchdog budget
   localparam int T1_FRAMES = 8;
   localparam int T1_WORDS  = T1_FRAMES * 8;
   localparam int T2_LEN    = 6;
   localparam int T2_WORDS  = TX_DEPTH - T2_LEN + 1;
   localparam int T3_PKTS   = 4;
   localparam int T3_WORDS  = T3_PKTS * 6;
   localparam int T4_WORDS  = TX_DEPTH + 2;
   localparam int T5_WORDS  = RX_DEPTH + 15;
   localparam int WATCHDOG_CYCLES =
      (T1_WORDS + T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS) * 40;

   localparam int BP_LOW    = 0;
   localparam int BP_HIGH   = 1;
   localparam int BP_RANDOM = 2;

   logic               fifo_clk;
   logic               arst_n_i;
   logic [WORD_W-1:0]  em_d_i;
   logic               em_ncs4_i;
   logic               em_nwe_i;
   logic               em_noe_i;
   logic [WORD_W-1:0]  em_d_o;
   logic               em_d_oe_o;
   logic               clear_tx_i;
   logic               clear_rx_i;
   logic [LEN_W-1:0]   tx_frame_len_i;
   logic [FRAME_W-1:0] tx_data_o;
   logic               tx_src_rdy_o;
   logic               tx_dst_rdy_i;
   logic [FRAME_W-1:0] rx_data_i;
   logic               rx_src_rdy_i;
   logic               rx_dst_rdy_o;
   logic               tx_have_space_o;
   logic               rx_have_data_o;
   logic [LEN_W-1:0]   rx_frame_len_o;
   logic               bus_error_o;

   // Reference state
   logic [FRAME_W-1:0] tx_exp[$];
   logic [FRAME_W-1:0] rx_exp[$];
   int                 rx_len[$];
   int                 tx_idx      = 0;
   int                 bp_mode     = BP_LOW;
   logic [31:0]        rnd_state   = SEED;
   int                 errors      = 0;
   int                 checks      = 0;
   int                 tests_run   = 0;
   int                 test_errors = 0;

   gpmc_async #(
      .TX_FIFO_AW  (TX_AW),
      .RX_FIFO_AW  (RX_AW),
      .LEN_FIFO_AW (LEN_AW)
   ) UUT (
      .fifo_clk        (fifo_clk),
      .arst_n_i        (arst_n_i),
      .em_d_i          (em_d_i),
      .em_ncs4_i       (em_ncs4_i),
      .em_nwe_i        (em_nwe_i),
      .em_noe_i        (em_noe_i),
      .em_d_o          (em_d_o),
      .em_d_oe_o       (em_d_oe_o),
      .clear_tx_i      (clear_tx_i),
      .clear_rx_i      (clear_rx_i),
      .tx_frame_len_i  (tx_frame_len_i),
      .tx_data_o       (tx_data_o),
      .tx_src_rdy_o    (tx_src_rdy_o),
      .tx_dst_rdy_i    (tx_dst_rdy_i),
      .rx_data_i       (rx_data_i),
      .rx_src_rdy_i    (rx_src_rdy_i),
      .rx_dst_rdy_o    (rx_dst_rdy_o),
      .tx_have_space_o (tx_have_space_o),
      .rx_have_data_o  (rx_have_data_o),
      .rx_frame_len_o  (rx_frame_len_o),
      .bus_error_o     (bus_error_o)
   );

   bind gpmc_async gpmc_async_assert u_assert (
      .fifo_clk       (fifo_clk),
      .arst_n_i       (arst_n_i),
      .em_ncs4_i      (em_ncs4_i),
      .em_noe_i       (em_noe_i),
      .em_d_oe_i      (em_d_oe_o),
      .clear_tx_i     (clear_tx_i),
      .tx_data_i      (tx_data_o),
      .tx_src_rdy_i   (tx_src_rdy_o),
      .tx_dst_rdy_i   (tx_dst_rdy_i),
      .rx_have_data_i (rx_have_data_o),
      .bus_error_i    (bus_error_o)
   );

   initial begin
      fifo_clk = 1'b0;
      forever #10 fifo_clk = ~fifo_clk;
   end

   ////////////////////////////////////////////////////////////
   // Reference model and helpers

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   // sof on index zero, eof on index len-1, zero length acts as one
   function automatic logic [FRAME_W-1:0] expected_frame_word(
      input logic [WORD_W-1:0] data, input int idx, input int len);
      int                 last;
      logic [FRAME_W-1:0] w;
      last = (len == 0) ? 0 : len - 1;
      w = '0;
      w[WORD_W-1:0] = data;
      w[SOF_BIT]    = (idx == 0);
      w[EOF_BIT]    = (idx == last);
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("Test %0d (%s) finished with %0d errors", tests_run, name,
               errors - test_errors);
      test_errors = errors;
   endtask

   task automatic set_backpressure(input int mode);
      @(posedge fifo_clk);
      bp_mode = mode;
      @(negedge fifo_clk);
   endtask

   // One host write; the word is expected on TX only when it fits
   task automatic host_write(input logic [WORD_W-1:0] data, input bit expect_push);
      logic [FRAME_W-1:0] w;
      if (expect_push) begin
         w = expected_frame_word(data, tx_idx, int'(tx_frame_len_i));
         tx_exp.push_back(w);
         // Index wraps after the eof word of each frame
         tx_idx = w[EOF_BIT] ? 0 : tx_idx + 1;
      end
      @(negedge fifo_clk);
      em_d_i    = data;
      em_ncs4_i = 1'b0;
      em_nwe_i  = 1'b0;
      repeat (3) @(negedge fifo_clk);
      em_nwe_i = 1'b1;
      repeat (4) @(negedge fifo_clk);
      em_ncs4_i = 1'b1;
      em_d_i    = '0;
      repeat (2) @(negedge fifo_clk);
   endtask

   task automatic host_read(input bit expect_word);
      logic [FRAME_W-1:0] exp_word;
      bit                 last_word;
      last_word = 1'b0;
      @(negedge fifo_clk);
      em_ncs4_i = 1'b0;
      em_noe_i  = 1'b0;
      repeat (3) @(negedge fifo_clk);
      check_value("em_d_oe_o", 32'(em_d_oe_o), 32'd1);
      if (expect_word) begin
         if (rx_exp.size() == 0) begin
            $display("Host read expected a word but none was sent on RX");
            errors++;
         end else begin
            exp_word  = rx_exp.pop_front();
            last_word = exp_word[EOF_BIT];
            check_value("em_d_o", 32'(em_d_o), 32'(exp_word[WORD_W-1:0]));
         end
      end
      em_noe_i = 1'b1;
      repeat (4) @(negedge fifo_clk);
      em_ncs4_i = 1'b1;
      repeat (2) @(negedge fifo_clk);
      // Next length moves to the head once the eof word is gone
      if (last_word) begin
         void'(rx_len.pop_front());
         if (rx_len.size() != 0) begin
            check_value("rx_frame_len_o", 32'(rx_frame_len_o), 32'(rx_len[0]));
         end
      end
   endtask

   task automatic send_packet(input int len);
      logic [FRAME_W-1:0] w;
      rx_len.push_back(len);
      for (int i = 0; i < len; i++) begin
         w = expected_frame_word(WORD_W'(next_rand()), i, len);
         rx_exp.push_back(w);
         @(negedge fifo_clk);
         rx_data_i    = w;
         rx_src_rdy_i = 1'b1;
         @(posedge fifo_clk);
         while (!rx_dst_rdy_o) @(posedge fifo_clk);
      end
      @(negedge fifo_clk);
      rx_src_rdy_i = 1'b0;
   endtask

   task automatic pulse_clear_tx();
      @(negedge fifo_clk);
      clear_tx_i = 1'b1;
      tx_exp.delete();
      tx_idx = 0;
      @(negedge fifo_clk);
      clear_tx_i = 1'b0;
   endtask

   task automatic pulse_clear_rx();
      @(negedge fifo_clk);
      clear_rx_i = 1'b1;
      rx_exp.delete();
      rx_len.delete();
      @(negedge fifo_clk);
      clear_rx_i = 1'b0;
   endtask

   task automatic wait_tx_drained();
      while (tx_exp.size() != 0 || tx_src_rdy_o) @(negedge fifo_clk);
   endtask

   ////////////////////////////////////////////////////////////
   // Back-pressure and TX monitor

   initial begin : backpressure
      logic [31:0] bp_state;
      bp_state     = xorshift32(SEED);
      tx_dst_rdy_i = 1'b0;
      forever begin
         @(negedge fifo_clk);
         if (bp_mode == BP_RANDOM) begin
            bp_state     = xorshift32(bp_state);
            tx_dst_rdy_i = bp_state[0];
         end else begin
            tx_dst_rdy_i = (bp_mode == BP_HIGH);
         end
      end
   end

   initial begin : tx_monitor
      logic [FRAME_W-1:0] exp_word;
      forever begin
         @(posedge fifo_clk);
         if (arst_n_i && !clear_tx_i && tx_src_rdy_o && tx_dst_rdy_i) begin
            if (tx_exp.size() == 0) begin
               $display("Unexpected word 0x%0h left on the TX stream", tx_data_o);
               errors++;
            end else begin
               exp_word = tx_exp.pop_front();
               check_value("tx_data_o", 32'(tx_data_o), 32'(exp_word));
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge fifo_clk);
      $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Test sequence

   initial begin : main
      int len;
      arst_n_i       = 1'b0;
      em_d_i         = '0;
      em_ncs4_i      = 1'b1;
      em_nwe_i       = 1'b1;
      em_noe_i       = 1'b1;
      clear_tx_i     = 1'b0;
      clear_rx_i     = 1'b0;
      tx_frame_len_i = LEN_W'(1);
      rx_data_i      = '0;
      rx_src_rdy_i   = 1'b0;
      repeat (5) @(negedge fifo_clk);
      arst_n_i = 1'b1;
      repeat (2) @(negedge fifo_clk);

      // TX framing under random back-pressure
      set_backpressure(BP_RANDOM);
      for (int f = 0; f < T1_FRAMES; f++) begin
         len = 1 + int'(next_rand() % 32'd8);
         tx_frame_len_i = LEN_W'(len);
         repeat (2) @(negedge fifo_clk);
         while (!tx_have_space_o) @(negedge fifo_clk);
         for (int i = 0; i < len; i++) begin
            host_write(WORD_W'(next_rand()), 1'b1);
         end
      end
      set_backpressure(BP_HIGH);
      wait_tx_drained();
      end_test("tx framing");

      // TX space status with the stream stalled
      pulse_clear_tx();
      set_backpressure(BP_LOW);
      tx_frame_len_i = LEN_W'(T2_LEN);
      repeat (2) @(negedge fifo_clk);
      check_value("tx_have_space_o", 32'(tx_have_space_o), 32'd1);
      for (int i = 0; i < T2_WORDS - 1; i++) begin
         host_write(WORD_W'(next_rand()), 1'b1);
      end
      check_value("tx_have_space_o", 32'(tx_have_space_o), 32'd1);
      host_write(WORD_W'(next_rand()), 1'b1);
      check_value("tx_have_space_o", 32'(tx_have_space_o), 32'd0);
      set_backpressure(BP_HIGH);
      wait_tx_drained();
      repeat (2) @(negedge fifo_clk);
      check_value("tx_have_space_o", 32'(tx_have_space_o), 32'd1);
      end_test("tx space status");

      // RX packets to the host
      for (int p = 0; p < T3_PKTS; p++) begin
         send_packet(1 + int'(next_rand() % 32'd6));
      end
      @(negedge fifo_clk);
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd1);
      check_value("rx_frame_len_o", 32'(rx_frame_len_o), 32'(rx_len[0]));
      while (rx_exp.size() != 0) host_read(1'b1);
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd0);
      end_test("rx packets");

      // Bus errors on both sides
      pulse_clear_tx();
      set_backpressure(BP_LOW);
      tx_frame_len_i = LEN_W'(4);
      for (int i = 0; i < TX_DEPTH; i++) begin
         host_write(WORD_W'(next_rand()), 1'b1);
      end
      // Buffer is full and stalled, so this word is dropped
      host_write(WORD_W'(next_rand()), 1'b0);
      check_value("bus_error_o", 32'(bus_error_o), 32'd1);
      set_backpressure(BP_HIGH);
      wait_tx_drained();
      repeat (4) @(negedge fifo_clk);
      check_value("tx_src_rdy_o", 32'(tx_src_rdy_o), 32'd0);
      pulse_clear_tx();
      check_value("bus_error_o", 32'(bus_error_o), 32'd0);
      host_read(1'b0);
      check_value("bus_error_o", 32'(bus_error_o), 32'd1);
      end_test("bus errors");

      // Clears on both sides
      set_backpressure(BP_LOW);
      for (int i = 0; i < 3; i++) begin
         host_write(WORD_W'(next_rand()), 1'b1);
      end
      check_value("tx_src_rdy_o", 32'(tx_src_rdy_o), 32'd1);
      pulse_clear_tx();
      check_value("tx_src_rdy_o", 32'(tx_src_rdy_o), 32'd0);
      // A full-depth packet leaves the RX buffer full
      send_packet(RX_DEPTH);
      check_value("rx_dst_rdy_o", 32'(rx_dst_rdy_o), 32'd0);
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd1);
      pulse_clear_rx();
      check_value("rx_dst_rdy_o", 32'(rx_dst_rdy_o), 32'd1);
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd0);
      check_value("bus_error_o", 32'(bus_error_o), 32'd0);
      send_packet(1 + int'(next_rand() % 32'd6));
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd1);
      check_value("rx_frame_len_o", 32'(rx_frame_len_o), 32'(rx_len[0]));
      while (rx_exp.size() != 0) host_read(1'b1);
      check_value("rx_have_data_o", 32'(rx_have_data_o), 32'd0);
      end_test("clears");

      $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/fifo_buffer.sv
// Register-array FIFO with first-word-fall-through output and free-space count
`default_nettype none

module fifo_buffer import gpmc_pkg::*; #(
   parameter int WIDTH = FRAME_W,
   parameter int AW    = 6
) (
   input  wire              fifo_clk,
   input  wire              arst_n_i,
   input  wire              clear_i,
   input  wire              wr_i,
   input  wire  [WIDTH-1:0] wdata_i,
   input  wire              rd_i,
   output logic [WIDTH-1:0] rdata_o,
   output logic             full_o,
   output logic             empty_o,
   output logic [LEN_W-1:0] space_o
);

   localparam int DEPTH = 1 << AW;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             do_wr;
   logic             do_rd;

   // Strobes into a full or empty buffer are ignored
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   // Head word is visible as soon as it is written
   assign rdata_o = mem[rd_ptr];

   // Count tops out at DEPTH, so its MSB alone means full
   assign full_o  = count[AW];
   assign empty_o = (count == '0);
   assign space_o = LEN_W'(DEPTH) - LEN_W'(count);

endmodule

`default_nettype wire

//--- verilog/frame_counter.sv
// TX word counter that marks the first and last word of each frame
`default_nettype none

module frame_counter import gpmc_pkg::*; (
   input  wire             fifo_clk,
   input  wire             arst_n_i,
   input  wire             clear_i,
   input  wire             advance_i,
   input  wire [LEN_W-1:0] frame_len_i,
   output logic            sof_o,
   output logic            eof_o
);

   logic [LEN_W-1:0] count;
   logic [LEN_W-1:0] last_idx;

   // A zero length acts as a one-word frame
   assign last_idx = (frame_len_i == '0) ? '0 : frame_len_i - 1'b1;

   assign sof_o = (count == '0);

   // Greater-or-equal so a shortened length still closes the frame
   assign eof_o = (count >= last_idx);

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count <= '0;
      end else if (clear_i) begin
         count <= '0;
      end else if (advance_i) begin
         if (eof_o) begin
            count <= '0;
         end else begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/gpmc_async.sv
// GPMC chip select 4 bridge between the async host bus and framed fifo_clk streams
`default_nettype none

module gpmc_async import gpmc_pkg::*; #(
   parameter int TX_FIFO_AW  = 6,
   parameter int RX_FIFO_AW  = 6,
   parameter int LEN_FIFO_AW = 3
) (
   input  wire                fifo_clk,
   input  wire                arst_n_i,

   // Host bus
   input  wire  [WORD_W-1:0]  em_d_i,
   input  wire                em_ncs4_i,
   input  wire                em_nwe_i,
   input  wire                em_noe_i,
   output logic [WORD_W-1:0]  em_d_o,
   output logic               em_d_oe_o,

   // Control
   input  wire                clear_tx_i,
   input  wire                clear_rx_i,
   input  wire  [LEN_W-1:0]   tx_frame_len_i,

   // TX stream
   output logic [FRAME_W-1:0] tx_data_o,
   output logic               tx_src_rdy_o,
   input  wire                tx_dst_rdy_i,

   // RX stream
   input  wire  [FRAME_W-1:0] rx_data_i,
   input  wire                rx_src_rdy_i,
   output logic               rx_dst_rdy_o,

   // Status
   output logic               tx_have_space_o,
   output logic               rx_have_data_o,
   output logic [LEN_W-1:0]   rx_frame_len_o,
   output logic               bus_error_o
);

   logic               tx_wr;
   logic [FRAME_W-1:0] tx_wdata;
   logic               tx_full;
   logic               tx_empty;
   logic [LEN_W-1:0]   tx_space;
   logic               tx_rd;
   logic               tx_error;

   logic               rx_wr;
   logic [FRAME_W-1:0] rx_rdata;
   logic               rx_full;
   logic               rx_empty;
   logic               rx_rd;
   logic               rx_error;

   ////////////////////////////////////////////////////////////
   // TX path: host writes into the framed stream

   gpmc_write_ctrl u_write_ctrl (
      .fifo_clk       (fifo_clk),
      .arst_n_i       (arst_n_i),
      .clear_i        (clear_tx_i),
      .em_d_i         (em_d_i),
      .em_ncs4_i      (em_ncs4_i),
      .em_nwe_i       (em_nwe_i),
      .tx_frame_len_i (tx_frame_len_i),
      .fifo_full_i    (tx_full),
      .fifo_space_i   (tx_space),
      .fifo_wr_o      (tx_wr),
      .fifo_data_o    (tx_wdata),
      .have_space_o   (tx_have_space_o),
      .error_o        (tx_error)
   );

   fifo_buffer #(
      .WIDTH (FRAME_W),
      .AW    (TX_FIFO_AW)
   ) tx_fifo (
      .fifo_clk (fifo_clk),
      .arst_n_i (arst_n_i),
      .clear_i  (clear_tx_i),
      .wr_i     (tx_wr),
      .wdata_i  (tx_wdata),
      .rd_i     (tx_rd),
      .rdata_o  (tx_data_o),
      .full_o   (tx_full),
      .empty_o  (tx_empty),
      .space_o  (tx_space)
   );

   assign tx_src_rdy_o = !tx_empty;
   assign tx_rd        = tx_src_rdy_o && tx_dst_rdy_i;

   ////////////////////////////////////////////////////////////
   // RX path: framed stream out to host reads

   assign rx_dst_rdy_o = !rx_full;
   assign rx_wr        = rx_src_rdy_i && rx_dst_rdy_o;

   fifo_buffer #(
      .WIDTH (FRAME_W),
      .AW    (RX_FIFO_AW)
   ) rx_fifo (
      .fifo_clk (fifo_clk),
      .arst_n_i (arst_n_i),
      .clear_i  (clear_rx_i),
      .wr_i     (rx_wr),
      .wdata_i  (rx_data_i),
      .rd_i     (rx_rd),
      .rdata_o  (rx_rdata),
      .full_o   (rx_full),
      .empty_o  (rx_empty),
      .space_o  ()
   );

   gpmc_read_port u_read_port (
      .fifo_clk     (fifo_clk),
      .arst_n_i     (arst_n_i),
      .clear_i      (clear_rx_i),
      .em_ncs4_i    (em_ncs4_i),
      .em_noe_i     (em_noe_i),
      .fifo_data_i  (rx_rdata[WORD_W-1:0]),
      .fifo_empty_i (rx_empty),
      .em_d_o       (em_d_o),
      .em_d_oe_o    (em_d_oe_o),
      .fifo_rd_o    (rx_rd),
      .error_o      (rx_error)
   );

   // Watches both ends of the RX buffer
   packet_watcher #(
      .AW     (RX_FIFO_AW),
      .LEN_AW (LEN_FIFO_AW)
   ) u_packet_watcher (
      .fifo_clk      (fifo_clk),
      .arst_n_i      (arst_n_i),
      .clear_i       (clear_rx_i),
      .in_accept_i   (rx_wr),
      .in_eof_i      (rx_data_i[EOF_BIT]),
      .out_pop_i     (rx_rd),
      .out_eof_i     (rx_rdata[EOF_BIT]),
      .have_packet_o (rx_have_data_o),
      .length_o      (rx_frame_len_o)
   );

   // Both flags are sticky in their own side
   assign bus_error_o = tx_error || rx_error;

endmodule

`default_nettype wire

//--- verilog/gpmc_pkg.sv
// GPMC bridge shared widths, frame flag positions and FSM state types
`default_nettype none

package gpmc_pkg;

   // Host bus word and framed stream word
   localparam int WORD_W  = 16;
   localparam int FRAME_W = 18;

   // Frame flags sit above the data bits
   localparam int SOF_BIT = 16;
   localparam int EOF_BIT = 17;

   // Frame lengths and buffer space counts
   localparam int LEN_W = 16;

   // Host write controller
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_STROBE,
      WR_PUSH,
      WR_DROP
   } wr_state_e;

   // Host read port
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ACTIVE,
      RD_POP
   } rd_state_e;

endpackage

`default_nettype wire

//--- verilog/gpmc_read_port.sv
// Host read port: drives the RX head word and pops it on each released output enable
`default_nettype none

module gpmc_read_port import gpmc_pkg::*; (
   input  wire               fifo_clk,
   input  wire               arst_n_i,
   input  wire               clear_i,
   input  wire               em_ncs4_i,
   input  wire               em_noe_i,
   input  wire  [WORD_W-1:0] fifo_data_i,
   input  wire               fifo_empty_i,
   output logic [WORD_W-1:0] em_d_o,
   output logic              em_d_oe_o,
   output logic              fifo_rd_o,
   output logic              error_o
);

   logic [1:0] ncs_sync;
   logic [1:0] noe_sync;
   logic       ncs_low;
   logic       noe_high;
   rd_state_e  state;
   rd_state_e  state_nxt;

   // Pin drive follows the raw strobes, no clock involved
   assign em_d_oe_o = !em_ncs4_i && !em_noe_i;
   assign em_d_o    = fifo_data_i;

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ncs_sync <= 2'b11;
         noe_sync <= 2'b11;
      end else begin
         ncs_sync <= {ncs_sync[0], em_ncs4_i};
         noe_sync <= {noe_sync[0], em_noe_i};
      end
   end

   assign ncs_low  = !ncs_sync[1];
   assign noe_high = noe_sync[1];

   always_comb begin
      state_nxt = state;
      case (state)
         RD_IDLE: begin
            if (ncs_low && !noe_high) begin
               state_nxt = RD_ACTIVE;
            end
         end
         RD_ACTIVE: begin
            if (noe_high) begin
               state_nxt = RD_POP;
            end else if (!ncs_low) begin
               state_nxt = RD_IDLE;
            end
         end
         default: state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= RD_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // One word per completed host read
   assign fifo_rd_o = (state == RD_POP) && !fifo_empty_i;

   // Sticky flag for reads that found nothing
   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         error_o <= 1'b0;
      end else if (clear_i) begin
         error_o <= 1'b0;
      end else if (state == RD_POP && fifo_empty_i) begin
         error_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/gpmc_write_ctrl.sv
// Host write controller: strobe sync, data capture and tagged push into the TX buffer
`default_nettype none

module gpmc_write_ctrl import gpmc_pkg::*; (
   input  wire                fifo_clk,
   input  wire                arst_n_i,
   input  wire                clear_i,
   input  wire  [WORD_W-1:0]  em_d_i,
   input  wire                em_ncs4_i,
   input  wire                em_nwe_i,
   input  wire  [LEN_W-1:0]   tx_frame_len_i,
   input  wire                fifo_full_i,
   input  wire  [LEN_W-1:0]   fifo_space_i,
   output logic               fifo_wr_o,
   output logic [FRAME_W-1:0] fifo_data_o,
   output logic               have_space_o,
   output logic               error_o
);

   logic [1:0]        ncs_sync;
   logic [1:0]        nwe_sync;
   logic              ncs_low;
   logic              nwe_high;
   logic [WORD_W-1:0] data_q;
   logic              sof;
   logic              eof;
   wr_state_e         state;
   wr_state_e         state_nxt;

   ////////////////////////////////////////////////////////////
   // Strobe synchronizers

   // Pins idle high
   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ncs_sync <= 2'b11;
         nwe_sync <= 2'b11;
      end else begin
         ncs_sync <= {ncs_sync[0], em_ncs4_i};
         nwe_sync <= {nwe_sync[0], em_nwe_i};
      end
   end

   assign ncs_low  = !ncs_sync[1];
   assign nwe_high = nwe_sync[1];

   ////////////////////////////////////////////////////////////
   // Write FSM

   // STROBE is held only while the chip select stays low
   always_comb begin
      state_nxt = state;
      case (state)
         WR_IDLE: begin
            if (ncs_low && !nwe_high) begin
               state_nxt = WR_STROBE;
            end
         end
         WR_STROBE: begin
            if (nwe_high) begin
               state_nxt = fifo_full_i ? WR_DROP : WR_PUSH;
            end else if (!ncs_low) begin
               state_nxt = WR_IDLE;
            end
         end
         default: state_nxt = WR_IDLE;
      endcase
   end

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= WR_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Bus data is still held by the host at the synchronized edge
   always_ff @(posedge fifo_clk) begin
      if (state == WR_STROBE && nwe_high) begin
         data_q <= em_d_i;
      end
   end

   assign fifo_wr_o = (state == WR_PUSH);

   frame_counter u_frame_counter (
      .fifo_clk    (fifo_clk),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear_i),
      .advance_i   (fifo_wr_o),
      .frame_len_i (tx_frame_len_i),
      .sof_o       (sof),
      .eof_o       (eof)
   );

   always_comb begin
      fifo_data_o               = '0;
      fifo_data_o[WORD_W-1:0]   = data_q;
      fifo_data_o[SOF_BIT]      = sof;
      fifo_data_o[EOF_BIT]      = eof;
   end

   ////////////////////////////////////////////////////////////
   // Status

   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         have_space_o <= 1'b0;
         error_o      <= 1'b0;
      end else begin
         have_space_o <= (fifo_space_i >= tx_frame_len_i);
         if (clear_i) begin
            error_o <= 1'b0;
         end else if (state == WR_DROP) begin
            error_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/packet_watcher.sv
// RX packet tracker: counts whole packets in the buffer and queues their lengths
`default_nettype none

module packet_watcher import gpmc_pkg::*; #(
   parameter int AW     = 6,
   parameter int LEN_AW = 3
) (
   input  wire              fifo_clk,
   input  wire              arst_n_i,
   input  wire              clear_i,
   input  wire              in_accept_i,
   input  wire              in_eof_i,
   input  wire              out_pop_i,
   input  wire              out_eof_i,
   output logic             have_packet_o,
   output logic [LEN_W-1:0] length_o
);

   logic [LEN_W-1:0] in_len;
   logic [LEN_W-1:0] done_len;
   logic [AW:0]      pkt_count;
   logic             pkt_in;
   logic             pkt_out;
   logic [LEN_W-1:0] head_len;
   logic             len_empty;

   assign pkt_in   = in_accept_i && in_eof_i;
   assign pkt_out  = out_pop_i && out_eof_i;
   assign done_len = in_len + 1'b1;

   // Words seen so far in the incoming packet
   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_len <= '0;
      end else if (clear_i) begin
         in_len <= '0;
      end else if (in_accept_i) begin
         in_len <= in_eof_i ? '0 : done_len;
      end
   end

   // Every packet holds at least one word, so AW+1 bits never overflow
   always_ff @(posedge fifo_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pkt_count <= '0;
      end else if (clear_i) begin
         pkt_count <= '0;
      end else begin
         case ({pkt_in, pkt_out})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

   // Lengths beyond the queue depth are lost
   fifo_buffer #(
      .WIDTH (LEN_W),
      .AW    (LEN_AW)
   ) len_queue (
      .fifo_clk (fifo_clk),
      .arst_n_i (arst_n_i),
      .clear_i  (clear_i),
      .wr_i     (pkt_in),
      .wdata_i  (done_len),
      .rd_i     (pkt_out),
      .rdata_o  (head_len),
      .full_o   (),
      .empty_o  (len_empty),
      .space_o  ()
   );

   assign have_packet_o = (pkt_count != '0);
   assign length_o      = len_empty ? '0 : head_len;

endmodule

`default_nettype wire
